//--- files.f
+incdir+hw
hw/ntt_pkg.sv
hw/delay_line.sv
hw/mod_add_sub.sv
hw/mod_mult_reduce.sv
hw/butterfly_ctrl.sv
hw/butterfly_datapath.sv
hw/ntt_butterfly_top.sv
tb/tb_ntt_butterfly.sv

//--- hw/butterfly_ctrl.sv
`timescale 1ns/100ps
`include "ntt_defines.svh"

module butterfly_ctrl
    import ntt_pkg::*;
(
    input  logic   clk,
    input  logic   reset_n,
    input  logic   zeroize_i,
    input  logic   valid_i,
    input  bf_op_t op_i,
    input  logic   accumulate_i,
    output bf_op_t s0_op_o,
    output bf_op_t s2_op_o,
    output logic   s0_acc_o,
    output logic   s2_acc_o,
    output logic   s3_valid_o
);

    // ======================================================================
    // Stage 0 selects
    // ======================================================================

    // Routing muxes act on the incoming set directly
    assign s0_op_o = op_i;

    // Accumulate is only meaningful for a strobed PWM set
    assign s0_acc_o = valid_i && accumulate_i && (op_i == OP_PWM);

    // ======================================================================
    // Delayed selects for the back adder and the output stage
    // ======================================================================

    // Valid travels the full latency and becomes valid_o
    delay_line #(
        .T     (logic),
        .DEPTH (`NTT_LATENCY)
    ) i_valid_dly (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .d_i       (valid_i),
        .q_o       (s3_valid_o)
    );

    // Operation of the set held by the back adder
    delay_line #(
        .T     (bf_op_t),
        .DEPTH (`NTT_LATENCY - 1)
    ) i_op_dly (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .d_i       (op_i),
        .q_o       (s2_op_o)
    );

    delay_line #(
        .T     (logic),
        .DEPTH (`NTT_LATENCY - 1)
    ) i_acc_dly (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .d_i       (s0_acc_o),
        .q_o       (s2_acc_o)
    );

endmodule

//--- hw/butterfly_datapath.sv
`timescale 1ns/100ps
`include "ntt_defines.svh"

module butterfly_datapath
    import ntt_pkg::*;
(
    input  logic   clk,
    input  logic   reset_n,
    input  logic   zeroize_i,
    input  coeff_t u_i,
    input  coeff_t v_i,
    input  coeff_t w_i,
    input  bf_op_t s0_op_i,
    input  bf_op_t s2_op_i,
    input  logic   s2_acc_i,
    input  logic   s3_valid_i,
    output coeff_t u_o,
    output coeff_t v_o,
    output coeff_t pwm_o
);

    coeff_t          u_d2;
    coeff_t          w_d2;
    coeff_t          front_sum;
    coeff_t          front_diff;
    coeff_t          front_sum_d2;
    coeff_t          front_diff_d2;
    logic [`NTT_W:0] gs_diff_raw;
    coeff_t          gs_diff;
    coeff_t          mul_a;
    coeff_t          mul_b;
    coeff_t          mul_p;
    coeff_t          back_a;
    coeff_t          back_b;
    coeff_t          back_sum;
    coeff_t          back_diff;
    bf_op_t          s3_op;

    // ======================================================================
    // Delay lines matching the multiplier latency
    // ======================================================================
    delay_line #(.T(coeff_t), .DEPTH(2)) i_u_dly (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i), .d_i(u_i), .q_o(u_d2)
    );

    delay_line #(.T(coeff_t), .DEPTH(2)) i_w_dly (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i), .d_i(w_i), .q_o(w_d2)
    );

    delay_line #(.T(coeff_t), .DEPTH(2)) i_fsum_dly (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i), .d_i(front_sum),
        .q_o(front_sum_d2)
    );

    delay_line #(.T(coeff_t), .DEPTH(2)) i_fdiff_dly (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i), .d_i(front_diff),
        .q_o(front_diff_d2)
    );

    // Output stage op, one past the back adder
    delay_line #(.T(bf_op_t), .DEPTH(1)) i_s3_op_dly (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i), .d_i(s2_op_i), .q_o(s3_op)
    );

    // ======================================================================
    // Front pair and multiplier
    // ======================================================================

    // GS halves here, PWA and PWS use the plain results
    mod_add_sub i_front (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i),
        .a_i(u_i), .b_i(v_i), .halve_i(s0_op_i == OP_GS),
        .sum_o(front_sum), .diff_o(front_diff)
    );

    // GS multiplies the unhalved difference, the back pair halves the product
    // so every operation uses the multiplier in the same slot
    assign gs_diff_raw = {1'b0, u_i} - {1'b0, v_i};
    assign gs_diff     = gs_diff_raw[`NTT_W] ? coeff_t'(gs_diff_raw + `NTT_Q)
                                             : coeff_t'(gs_diff_raw);

    always_comb begin
        mul_a = '0;
        mul_b = '0;
        case (s0_op_i)
            OP_CT: begin
                mul_a = v_i;
                mul_b = w_i;
            end
            OP_GS: begin
                mul_a = gs_diff;
                mul_b = w_i;
            end
            OP_PWM: begin
                mul_a = u_i;
                mul_b = v_i;
            end
            default: ;
        endcase
    end

    mod_mult_reduce i_mult (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i),
        .a_i(mul_a), .b_i(mul_b), .p_o(mul_p)
    );

    // ======================================================================
    // Back pair
    // ======================================================================
    always_comb begin
        back_a = '0;
        back_b = '0;
        case (s2_op_i)
            OP_CT: begin
                back_a = u_d2;
                back_b = mul_p;
            end
            OP_GS: back_a = mul_p;
            OP_PWM: begin
                // Plain PWM passes the product with zero
                back_a = mul_p;
                back_b = s2_acc_i ? w_d2 : '0;
            end
            default: ;
        endcase
    end

    mod_add_sub i_back (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i),
        .a_i(back_a), .b_i(back_b), .halve_i(s2_op_i == OP_GS),
        .sum_o(back_sum), .diff_o(back_diff)
    );

    // Output mux, zero outside a result cycle
    always_comb begin
        u_o   = '0;
        v_o   = '0;
        pwm_o = '0;
        if (s3_valid_i) begin
            case (s3_op)
                OP_CT: begin
                    u_o = back_sum;
                    v_o = back_diff;
                end
                OP_GS: begin
                    u_o = front_sum_d2;
                    v_o = back_sum;
                end
                OP_PWM:  pwm_o = back_sum;
                OP_PWA:  pwm_o = front_sum_d2;
                OP_PWS:  pwm_o = front_diff_d2;
                default: ;
            endcase
        end
    end

endmodule

//--- hw/delay_line.sv
`timescale 1ns/100ps

module delay_line #(
    parameter type T     = logic,
    parameter int  DEPTH = 1
) (
    input  logic clk,
    input  logic reset_n,
    input  logic zeroize_i,
    input  T     d_i,
    output T     q_o
);

    // Entry 0 takes the input, the last entry drives the output
    T stage_q [DEPTH];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage_q[i] <= T'(0);
            end
        end else if (zeroize_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage_q[i] <= T'(0);
            end
        end else begin
            stage_q[0] <= d_i;
            for (int i = 1; i < DEPTH; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign q_o = stage_q[DEPTH-1];

endmodule

//--- hw/mod_add_sub.sv
`timescale 1ns/100ps
`include "ntt_defines.svh"

module mod_add_sub
    import ntt_pkg::*;
(
    input  logic   clk,
    input  logic   reset_n,
    input  logic   zeroize_i,
    input  coeff_t a_i,
    input  coeff_t b_i,
    input  logic   halve_i,
    output coeff_t sum_o,
    output coeff_t diff_o
);

    // One extra bit for carry and borrow
    logic [`NTT_W:0] sum_raw;
    logic [`NTT_W:0] diff_raw;
    coeff_t          sum_mod;
    coeff_t          diff_mod;
    coeff_t          sum_res;
    coeff_t          diff_res;

    // x/2 mod q: an odd x becomes (x>>1) + (q+1)/2
    function automatic coeff_t mod_half(input coeff_t x);
        coeff_t shifted;
        shifted  = x >> 1;
        mod_half = x[0] ? shifted + `NTT_Q_HALF : shifted;
    endfunction

    assign sum_raw  = a_i + b_i;
    assign diff_raw = {1'b0, a_i} - {1'b0, b_i};

    // Single correction each since both operands are below q
    assign sum_mod  = (sum_raw >= `NTT_Q) ? coeff_t'(sum_raw - `NTT_Q) : coeff_t'(sum_raw);
    assign diff_mod = diff_raw[`NTT_W] ? coeff_t'(diff_raw + `NTT_Q) : coeff_t'(diff_raw);

    assign sum_res  = halve_i ? mod_half(sum_mod) : sum_mod;
    assign diff_res = halve_i ? mod_half(diff_mod) : diff_mod;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            sum_o  <= '0;
            diff_o <= '0;
        end else if (zeroize_i) begin
            sum_o  <= '0;
            diff_o <= '0;
        end else begin
            sum_o  <= sum_res;
            diff_o <= diff_res;
        end
    end

endmodule

//--- hw/mod_mult_reduce.sv
`timescale 1ns/100ps
`include "ntt_defines.svh"

module mod_mult_reduce
    import ntt_pkg::*;
(
    input  logic   clk,
    input  logic   reset_n,
    input  logic   zeroize_i,
    input  coeff_t a_i,
    input  coeff_t b_i,
    output coeff_t p_o
);

    localparam int PW = 2 * `NTT_W;

    // Full product and its Barrett estimate
    logic [PW-1:0]       prod_q;
    logic [PW+`NTT_W:0]  est_full;
    logic [`NTT_W:0]     quot;
    logic [PW-1:0]       quot_times_q;
    logic [`NTT_W:0]     rem;
    coeff_t              red;

    // ======================================================================
    // Stage 1: product register
    // ======================================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            prod_q <= '0;
        end else if (zeroize_i) begin
            prod_q <= '0;
        end else begin
            prod_q <= a_i * b_i;
        end
    end

    // ======================================================================
    // Stage 2: Barrett reduction
    // ======================================================================

    // Quotient estimate is at most one short, so rem stays below 2q
    assign est_full     = prod_q * `NTT_BARRETT_M;
    assign quot         = est_full[PW+`NTT_W:`NTT_BARRETT_K];
    assign quot_times_q = quot * `NTT_Q;

    // Low bits are enough since the true remainder fits in W+1 bits
    assign rem = prod_q[`NTT_W:0] - quot_times_q[`NTT_W:0];
    assign red = (rem >= `NTT_Q) ? coeff_t'(rem - `NTT_Q) : coeff_t'(rem);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            p_o <= '0;
        end else if (zeroize_i) begin
            p_o <= '0;
        end else begin
            p_o <= red;
        end
    end

endmodule

//--- hw/ntt_butterfly_top.sv
`timescale 1ns/100ps

module ntt_butterfly_top
    import ntt_pkg::*;
(
    input  logic   clk,
    input  logic   reset_n,
    input  logic   valid_i,
    input  bf_op_t op_i,
    input  logic   accumulate_i,
    input  logic   zeroize_i,
    input  coeff_t u_i,
    input  coeff_t v_i,
    input  coeff_t w_i,
    output logic   valid_o,
    output coeff_t u_o,
    output coeff_t v_o,
    output coeff_t pwm_o
);

    bf_op_t s0_op;
    bf_op_t s2_op;
    logic   s2_acc;

    // Stage selects and the final valid
    butterfly_ctrl i_ctrl (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .valid_i      (valid_i),
        .op_i         (op_i),
        .accumulate_i (accumulate_i),
        .s0_op_o      (s0_op),
        .s2_op_o      (s2_op),
        .s0_acc_o     (),
        .s2_acc_o     (s2_acc),
        .s3_valid_o   (valid_o)
    );

    butterfly_datapath i_datapath (
        .clk        (clk),
        .reset_n    (reset_n),
        .zeroize_i  (zeroize_i),
        .u_i        (u_i),
        .v_i        (v_i),
        .w_i        (w_i),
        .s0_op_i    (s0_op),
        .s2_op_i    (s2_op),
        .s2_acc_i   (s2_acc),
        .s3_valid_i (valid_o),
        .u_o        (u_o),
        .v_o        (v_o),
        .pwm_o      (pwm_o)
    );

endmodule

//--- hw/ntt_defines.svh
`ifndef NTT_DEFINES_SVH
`define NTT_DEFINES_SVH

// Coefficient width and the modulus
`define NTT_W 12
`define NTT_Q 12'd3329

// (q+1)/2, added when halving an odd residue
`define NTT_Q_HALF 12'd1665

// Barrett constants for 24-bit products
// m = floor(2^k / q) with k = 2*NTT_W
`define NTT_BARRETT_M 13'd5039
`define NTT_BARRETT_K 24

// Strobe to result, in clock cycles
`define NTT_LATENCY 3

`endif

//--- hw/ntt_pkg.sv
`include "ntt_defines.svh"

package ntt_pkg;

    // ======================================================================
    // Coefficient and operation types
    // ======================================================================

    // Residue modulo q, below q on valid data
    typedef logic [`NTT_W-1:0] coeff_t;

    // Butterfly operation select
    typedef enum logic [2:0] {
        OP_CT  = 3'd0,  // Forward Cooley-Tukey
        OP_GS  = 3'd1,  // Inverse Gentleman-Sande with halving
        OP_PWM = 3'd2,  // Point-wise multiply, optional accumulate
        OP_PWA = 3'd3,  // Point-wise add
        OP_PWS = 3'd4   // Point-wise subtract
    } bf_op_t;

endpackage

//--- run_sim.sh
#!/bin/sh
# Build and run the butterfly testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f files.f \
    --top-module tb_ntt_butterfly -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"

//--- tb/tb_ntt_butterfly.sv
`timescale 1ns/100ps

module tb_ntt_butterfly
    import ntt_pkg::*;
();

    localparam int CLK_PERIOD      = 100;
    localparam int RESET_CYCLES    = 10;
    localparam int LATENCY         = 3;
    localparam int Q               = 3329;
    localparam int Q_HALF          = 1665;
    localparam int TABLE_ROWS      = 18;
    localparam int RANDOM_SETS     = 200;
    localparam int WATCHDOG_CYCLES = TABLE_ROWS + RANDOM_SETS + 50;

    // One stimulus row with its expected outputs
    typedef struct packed {
        bf_op_t op;
        logic   acc;
        coeff_t u;
        coeff_t v;
        coeff_t w;
        coeff_t eu;
        coeff_t ev;
        coeff_t epwm;
    } row_t;

    // Expected result and the cycle it must appear in
    typedef struct packed {
        coeff_t      u;
        coeff_t      v;
        coeff_t      pwm;
        logic [31:0] cyc;
    } expect_t;

    logic   clk = 1'b0;
    logic   reset_n;
    logic   valid_i;
    bf_op_t op_i;
    logic   accumulate_i;
    logic   zeroize_i;
    coeff_t u_i;
    coeff_t v_i;
    coeff_t w_i;
    logic   valid_o;
    coeff_t u_o;
    coeff_t v_o;
    coeff_t pwm_o;

    row_t        stim_table [TABLE_ROWS];
    expect_t     exp_q [$];
    logic [31:0] cycle_cnt = '0;
    int          value_errors = 0;
    int          protocol_errors = 0;
    int          checks_done = 0;
    int          seed;

    ntt_butterfly_top i_dut (
        .clk          (clk),
        .reset_n      (reset_n),
        .valid_i      (valid_i),
        .op_i         (op_i),
        .accumulate_i (accumulate_i),
        .zeroize_i    (zeroize_i),
        .u_i          (u_i),
        .v_i          (v_i),
        .w_i          (w_i),
        .valid_o      (valid_o),
        .u_o          (u_o),
        .v_o          (v_o),
        .pwm_o        (pwm_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // ======================================================================
    // Reference model
    // ======================================================================
    function automatic int mod_q(input int x);
        mod_q = ((x % Q) + Q) % Q;
    endfunction

    // x/2 modulo q for 0 <= x < q
    function automatic int half_q(input int x);
        if (x % 2 == 0) begin
            half_q = x / 2;
        end else begin
            half_q = x / 2 + Q_HALF;
        end
    endfunction

    task automatic ref_butterfly(input bf_op_t op, input logic acc, input int u,
                                 input int v, input int w, output int eu,
                                 output int ev, output int epwm);
        int prod;
        eu   = 0;
        ev   = 0;
        epwm = 0;
        case (op)
            OP_CT: begin
                prod = mod_q(v * w);
                eu   = mod_q(u + prod);
                ev   = mod_q(u - prod);
            end
            OP_GS: begin
                eu = half_q(mod_q(u + v));
                ev = mod_q(half_q(mod_q(u - v)) * w);
            end
            OP_PWM:  epwm = mod_q(u * v + (acc ? w : 0));
            OP_PWA:  epwm = mod_q(u + v);
            OP_PWS:  epwm = mod_q(u - v);
            default: ;
        endcase
    endtask

    // ======================================================================
    // Stimulus table
    // ======================================================================
    task automatic set_row(input int idx, input bf_op_t op, input logic acc,
                           input int u, input int v, input int w,
                           input int eu, input int ev, input int ep);
        stim_table[idx] = '{op, acc, coeff_t'(u), coeff_t'(v), coeff_t'(w),
                            coeff_t'(eu), coeff_t'(ev), coeff_t'(ep)};
    endtask

    task automatic load_table();
        // Forward butterflies with zero, q-1 and w = 1
        set_row(0,  OP_CT,  1'b0, 0,    0,    0,    0,    0,    0);
        set_row(1,  OP_CT,  1'b0, 3328, 3328, 1,    3327, 0,    0);
        set_row(2,  OP_CT,  1'b0, 1,    3328, 3328, 2,    0,    0);
        set_row(3,  OP_CT,  1'b0, 0,    5,    7,    35,   3294, 0);
        set_row(4,  OP_CT,  1'b0, 100,  17,   1729, 2861, 668,  0);
        // Inverse butterflies where odd sums and differences need halving
        set_row(5,  OP_GS,  1'b0, 1,    2,    1,    1666, 1664, 0);
        set_row(6,  OP_GS,  1'b0, 3328, 3328, 5,    3328, 0,    0);
        set_row(7,  OP_GS,  1'b0, 0,    0,    3328, 0,    0,    0);
        set_row(8,  OP_GS,  1'b0, 10,   3,    2,    1671, 7,    0);
        set_row(9,  OP_GS,  1'b0, 2,    3328, 3328, 1665, 1663, 0);
        // Point-wise operations
        set_row(10, OP_PWM, 1'b0, 3328, 3328, 99,   0,    0,    1);
        set_row(11, OP_PWM, 1'b1, 3328, 3328, 3000, 0,    0,    3001);
        set_row(12, OP_PWM, 1'b1, 12,   34,   5,    0,    0,    413);
        set_row(13, OP_PWM, 1'b0, 1000, 1000, 0,    0,    0,    1300);
        set_row(14, OP_PWA, 1'b0, 3328, 2,    0,    0,    0,    1);
        set_row(15, OP_PWA, 1'b1, 1234, 567,  8,    0,    0,    1801);
        set_row(16, OP_PWS, 1'b0, 0,    1,    0,    0,    0,    3328);
        set_row(17, OP_PWS, 1'b0, 3000, 328,  0,    0,    0,    2672);
    endtask

    // ======================================================================
    // Drivers
    // ======================================================================
    task automatic drive_set(input bf_op_t op, input logic acc, input coeff_t u,
                             input coeff_t v, input coeff_t w, input coeff_t eu,
                             input coeff_t ev, input coeff_t ep);
        expect_t e;
        @(posedge clk);
        valid_i      <= 1'b1;
        op_i         <= op;
        accumulate_i <= acc;
        zeroize_i    <= 1'b0;
        u_i          <= u;
        v_i          <= v;
        w_i          <= w;
        e.u   = eu;
        e.v   = ev;
        e.pwm = ep;
        // Strobe is held in cycle cycle_cnt + 1
        e.cyc = cycle_cnt + 1 + LATENCY;
        exp_q.push_back(e);
    endtask

    // Operands stay nonzero while valid_i is low
    // Sum, difference and product are all nonzero for every operation
    task automatic drive_idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            valid_i      <= 1'b0;
            accumulate_i <= 1'b0;
            zeroize_i    <= 1'b0;
            u_i          <= 12'd1000;
            v_i          <= 12'd7;
            w_i          <= 12'd21;
        end
    endtask

    task automatic drive_row(input int idx);
        drive_set(stim_table[idx].op, stim_table[idx].acc, stim_table[idx].u,
                  stim_table[idx].v, stim_table[idx].w, stim_table[idx].eu,
                  stim_table[idx].ev, stim_table[idx].epwm);
    endtask

    // Every set still in flight is dropped
    task automatic drive_zeroize(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            valid_i   <= 1'b0;
            zeroize_i <= 1'b1;
            exp_q.delete();
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < LATENCY + 4) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("Missing valid_o at %0t: %0d result(s) never came out",
                     $time, exp_q.size());
            protocol_errors += exp_q.size();
            exp_q.delete();
        end
    endtask

    // ======================================================================
    // Output monitor sampled on the falling edge
    // ======================================================================
    always @(negedge clk) begin
        expect_t e;
        if (valid_o) begin
            if (exp_q.size() == 0) begin
                $display("Unexpected valid_o at %0t with no set in flight", $time);
                protocol_errors++;
            end else begin
                e = exp_q.pop_front();
                checks_done++;
                if (cycle_cnt != e.cyc) begin
                    $display("valid_o at %0t came in cycle %0d instead of cycle %0d",
                             $time, cycle_cnt, e.cyc);
                    protocol_errors++;
                end
                if (u_o != e.u) begin
                    $display("CHECK FAILED at %0t: u_o = %0d, expected %0d",
                             $time, u_o, e.u);
                    value_errors++;
                end
                if (v_o != e.v) begin
                    $display("CHECK FAILED at %0t: v_o = %0d, expected %0d",
                             $time, v_o, e.v);
                    value_errors++;
                end
                if (pwm_o != e.pwm) begin
                    $display("CHECK FAILED at %0t: pwm_o = %0d, expected %0d",
                             $time, pwm_o, e.pwm);
                    value_errors++;
                end
            end
        end else if (u_o != '0 || v_o != '0 || pwm_o != '0) begin
            $display("CHECK FAILED at %0t: outputs not zero while valid_o is low",
                     $time);
            value_errors++;
        end
    end

    // ======================================================================
    // Test sequence
    // ======================================================================
    initial begin
        int     op_sel;
        int     eu;
        int     ev;
        int     ep;
        bf_op_t op;
        logic   acc;
        coeff_t u;
        coeff_t v;
        coeff_t w;

        reset_n      = 1'b0;
        valid_i      = 1'b0;
        op_i         = OP_CT;
        accumulate_i = 1'b0;
        zeroize_i    = 1'b0;
        u_i          = '0;
        v_i          = '0;
        w_i          = '0;
        seed         = 82;
        load_table();

        repeat (RESET_CYCLES) @(posedge clk);
        reset_n <= 1'b1;

        // No strobes right after reset
        drive_idle(3);

        // Whole table back to back with mixed operations
        for (int i = 0; i < TABLE_ROWS; i++) begin
            drive_row(i);
        end
        drive_idle(1);
        wait_drain();

        // Zeroize with two sets in flight
        drive_row(4);
        drive_row(9);
        drive_zeroize(2);
        drive_idle(4);

        // Recovery after zeroize
        drive_row(12);
        drive_idle(1);
        wait_drain();

        // Random sets over all five operations
        for (int n = 0; n < RANDOM_SETS; n++) begin
            op_sel = int'($unsigned($random(seed)) % 5);
            op     = bf_op_t'(op_sel[2:0]);
            acc    = $random(seed) & 1;
            u      = coeff_t'($unsigned($random(seed)) % Q);
            v      = coeff_t'($unsigned($random(seed)) % Q);
            w      = coeff_t'($unsigned($random(seed)) % Q);
            ref_butterfly(op, acc, int'(u), int'(v), int'(w), eu, ev, ep);
            drive_set(op, acc, u, v, w, coeff_t'(eu), coeff_t'(ev), coeff_t'(ep));
        end
        drive_idle(1);
        wait_drain();

        $display("Results checked: %0d, value errors: %0d, protocol errors: %0d",
                 checks_done, value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // Bound on the whole run
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired at %0t before the test sequence finished", $time);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule
